// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := decode_core_tb
FILELIST := filelist.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Fails on a nonzero exit or on the fail message in the log
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Verification failed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/decode_core_checker.sv ====
// Handshake assertions for the pipeline top level
// Stream hold rules, reset state and the invalid pulse
`timescale 1ns/100ps
`default_nettype none

module decode_core_checker (
    input logic          sink,
    input logic          reset,
    input logic          in_valid,
    input logic          in_ready,
    input core_pkg::id_t in_data,
    input logic          wb_valid,
    input logic          wb_ready,
    input core_pkg::wb_t wb_data,
    input logic          invalid
);

    // A raised valid keeps its payload until taken
    in_hold: assert property (@(posedge sink) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("input stream dropped or changed an item before acceptance");

    wb_hold: assert property (@(posedge sink) disable iff (reset)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data))
        else $error("write-back stream dropped or changed an item before acceptance");

    wb_reset: assert property (@(posedge sink) reset |=> !wb_valid)
        else $error("write-back valid high after reset");

    ready_reset: assert property (@(posedge sink) reset |=> in_ready)
        else $error("input ready low after reset");

    invalid_pulse: assert property (@(posedge sink) invalid |-> in_valid)
        else $error("invalid raised without an input item");

endmodule

`default_nettype wire

// ==== bench/decode_core_tb.sv ====
// Testbench for the decode pipeline top level
// Instruction table with expected results, input driver,
// write-back monitor under random back-pressure, summary
`timescale 1ns/100ps
`default_nettype none

module decode_core_tb;

    localparam int LIMIT       = 100;
    localparam int OPC_OP      = 'h33;
    localparam int OPC_IMM     = 'h13;
    localparam int OPC_LUI     = 'h37;
    localparam int OPC_AUIPC   = 'h17;
    localparam int OPC_JALR    = 'h67;
    localparam int OPC_LOAD    = 'h03;
    localparam int OPC_STORE   = 'h23;

    typedef struct packed {
        core_pkg::word_t pc;
        logic [31:0]     ir;
        logic            inv;
        core_pkg::addr_t rd;
        core_pkg::word_t data;
        logic            taken;
        core_pkg::word_t target;
    } row_t;

    logic                sink;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    core_pkg::id_t       in_data;
    logic                wb_valid;
    logic                wb_ready;
    core_pkg::wb_t       wb_data;
    core_pkg::redirect_t redirect;
    logic                invalid;

    row_t        rows[$];
    string       names[$];
    int          row_err[$];
    int          pending[$];
    int          errors = 0;
    int          bad_tests = 0;
    int          done_tests = 0;
    logic        timed_out = 1'b0;
    logic [31:0] next_pc = 32'h100;
    logic [31:0] lfsr;

    decode_core i_decode_core (
        .sink     (sink),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .redirect (redirect),
        .invalid  (invalid)
    );

    bind decode_core decode_core_checker i_checker (
        .sink     (sink),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .invalid  (invalid)
    );

    function automatic logic [31:0] enc_i(input int op, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_r(input int op, input int f7, input int f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_u(input int op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic add_row(input string name, input logic [31:0] ir, input logic inv,
                           input int rd, input int data, input logic taken, input int target);
        row_t r;
        r.pc     = next_pc;
        r.ir     = ir;
        r.inv    = inv;
        r.rd     = core_pkg::addr_t'(rd);
        r.data   = data;
        r.taken  = taken;
        r.target = target;
        if (!inv) begin
            pending.push_back(rows.size());
        end
        rows.push_back(r);
        names.push_back(name);
        row_err.push_back(0);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic alu(input string name, input logic [31:0] ir, input int rd, input int data);
        add_row(name, ir, 1'b0, rd, data, 1'b0, 0);
    endtask

    task automatic link(input string name, input logic [31:0] ir, input int rd,
                        input int data, input int target);
        add_row(name, ir, 1'b0, rd, data, 1'b1, target);
    endtask

    task automatic branch(input string name, input logic [31:0] ir, input logic taken,
                          input int target);
        add_row(name, ir, 1'b0, 0, 0, taken, target);
    endtask

    task automatic bad(input string name, input logic [31:0] ir);
        add_row(name, ir, 1'b1, 0, 0, 1'b0, 0);
    endtask

    task automatic build_table();
        // 0x100 immediate ALU ops
        alu("addi", enc_i(OPC_IMM, 0, 1, 0, 100), 1, 'h64);
        alu("addi_neg", enc_i(OPC_IMM, 0, 2, 0, -7), 2, 'hffff_fff9);
        alu("slti", enc_i(OPC_IMM, 2, 3, 2, 5), 3, 1);
        alu("sltiu", enc_i(OPC_IMM, 3, 4, 2, 5), 4, 0);
        alu("xori", enc_i(OPC_IMM, 4, 5, 1, 'hf0), 5, 'h94);
        alu("ori", enc_i(OPC_IMM, 6, 6, 1, 'h703), 6, 'h767);
        alu("andi", enc_i(OPC_IMM, 7, 7, 2, 'hff), 7, 'hf9);
        alu("slli", enc_i(OPC_IMM, 1, 8, 1, 4), 8, 'h640);
        alu("srli", enc_i(OPC_IMM, 5, 9, 2, 4), 9, 'h0fff_ffff);
        alu("srai", enc_i(OPC_IMM, 5, 10, 2, 'h402), 10, 'hffff_fffe);
        // 0x128 register ops, back to back dependencies
        alu("add", enc_r(OPC_OP, 0, 0, 11, 1, 2), 11, 'h5d);
        alu("sub_exe", enc_r(OPC_OP, 'h20, 0, 12, 11, 1), 12, 'hffff_fff9);
        alu("sra_exe_wb", enc_r(OPC_OP, 'h20, 5, 13, 12, 11), 13, 'hffff_ffff);
        alu("xor_x0", enc_r(OPC_OP, 0, 4, 14, 13, 0), 14, 'hffff_ffff);
        alu("add_to_x0", enc_r(OPC_OP, 0, 0, 0, 14, 14), 0, 0);
        alu("or_from_x0", enc_r(OPC_OP, 0, 6, 15, 0, 12), 15, 'hffff_fff9);
        alu("slt", enc_r(OPC_OP, 0, 2, 16, 12, 1), 16, 1);
        alu("srl_exe", enc_r(OPC_OP, 0, 5, 18, 12, 16), 18, 'h7fff_fffc);
        alu("sll_wb", enc_r(OPC_OP, 0, 1, 19, 16, 1), 19, 'h10);
        alu("sltu", enc_r(OPC_OP, 0, 3, 17, 12, 1), 17, 0);
        alu("and_wb", enc_r(OPC_OP, 0, 7, 20, 19, 5), 20, 'h10);
        // 0x154 upper immediates and jumps
        alu("lui", enc_u(OPC_LUI, 21, 'h12345), 21, 'h1234_5000);
        alu("auipc", enc_u(OPC_AUIPC, 22, 1), 22, 'h1158);
        link("jal", enc_j(23, 'h40), 23, 'h160, 'h19c);
        link("jalr", enc_i(OPC_JALR, 0, 24, 23, 7), 24, 'h164, 'h166);
        // 0x164 branches, rd field bits must not reach x8 or x1
        branch("beq", enc_b(0, 1, 1, 8), 1'b1, 'h16c);
        branch("bne", enc_b(1, 1, 1, 8), 1'b0, 0);
        branch("blt", enc_b(4, 2, 1, -16), 1'b1, 'h15c);
        branch("bge", enc_b(5, 2, 1, 'h20), 1'b0, 0);
        branch("bltu", enc_b(6, 2, 1, 'h20), 1'b0, 0);
        branch("bgeu", enc_b(7, 2, 1, 'h800), 1'b1, 'h978);
        alu("read_after_br", enc_r(OPC_OP, 0, 0, 25, 8, 1), 25, 'h6a4);
        // 0x180 encodings outside the supported set
        bad("lw", enc_i(OPC_LOAD, 2, 27, 1, 0));
        bad("sw", enc_r(OPC_STORE, 0, 2, 4, 2, 1));
        bad("zero_word", 0);
        bad("ecall", 'h73);
        bad("mul", enc_r(OPC_OP, 1, 0, 28, 1, 1));
        alu("after_bad", enc_i(OPC_IMM, 0, 27, 27, 1), 27, 1);
    endtask

    task automatic note_error(input int idx);
        errors++;
        row_err[idx]++;
    endtask

    task automatic report_test(input int idx);
        done_tests++;
        if (row_err[idx] != 0) begin
            bad_tests++;
        end
        $display("test %s: %s", names[idx], row_err[idx] == 0 ? "ok" : "error");
    endtask

    task automatic drive_rows();
        int waited;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            in_valid <= 1'b1;
            in_data  <= {rows[i].pc, rows[i].ir};
            waited = 0;
            do begin
                @(posedge sink);
                waited++;
            end while (!in_ready && waited < LIMIT);
            if (!in_ready) begin
                $display("timeout: %s was never accepted", names[i]);
                errors++;
                timed_out = 1'b1;
            end else begin
                assert (invalid == rows[i].inv) else begin
                    $display("mismatch %s invalid: expected %0b, actual %0b",
                             names[i], rows[i].inv, invalid);
                    note_error(i);
                end
                if (rows[i].inv) begin
                    report_test(i);
                end
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_result(input int idx);
        row_t r;
        r = rows[idx];
        assert (wb_data.rd == r.rd) else begin
            $display("mismatch %s rd: expected %0d, actual %0d", names[idx], r.rd, wb_data.rd);
            note_error(idx);
        end
        // Data is a don't-care when nothing is written
        if (r.rd != '0) begin
            assert (wb_data.data == r.data) else begin
                $display("mismatch %s data: expected %h, actual %h",
                         names[idx], r.data, wb_data.data);
                note_error(idx);
            end
        end
        assert (redirect.taken == r.taken) else begin
            $display("mismatch %s taken: expected %0b, actual %0b",
                     names[idx], r.taken, redirect.taken);
            note_error(idx);
        end
        if (r.taken) begin
            assert (redirect.target == r.target) else begin
                $display("mismatch %s target: expected %h, actual %h",
                         names[idx], r.target, redirect.target);
                note_error(idx);
            end
        end
        report_test(idx);
    endtask

    task automatic watch_results();
        int waited;
        int idx;
        while (pending.size() > 0 && !timed_out) begin
            waited = 0;
            do begin
                @(posedge sink);
                waited++;
            end while (!(wb_valid && wb_ready) && waited < LIMIT && !timed_out);
            if (wb_valid && wb_ready) begin
                idx = pending.pop_front();
                check_result(idx);
            end else if (!timed_out) begin
                $display("timeout: no write-back arrived for %s", names[pending[0]]);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // Nothing may follow the last expected result
    task automatic check_quiet();
        repeat (8) begin
            @(posedge sink);
            assert (!wb_valid) else begin
                $display("unexpected extra write-back to x%0d", wb_data.rd);
                errors++;
            end
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d of %0d tests done, %0d with errors, %0d failed checks",
                 done_tests, rows.size(), bad_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin
        sink = 1'b0;
        forever #20 sink = ~sink;
    end

    // Random back-pressure on the write-back stream
    initial begin
        wb_ready = 1'b0;
        lfsr     = 32'hf66c;
        forever begin
            @(posedge sink);
            lfsr = lfsr_next(lfsr);
            wb_ready <= lfsr[0];
        end
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        build_table();
        repeat (2) @(posedge sink);
        reset <= 1'b0;
        fork
            drive_rows();
            watch_results();
        join
        if (!timed_out) begin
            check_quiet();
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/core_pkg.sv
src/regfile.sv
src/forward_unit.sv
src/decode.sv
src/execute.sv
src/decode_core.sv
bench/decode_core_checker.sv
bench/decode_core_tb.sv

// ==== src/core_pkg.sv ====
// Shared types for the RV32I decode pipeline
// Word and register index types, instruction format union,
// control enums and the stage payload structs
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  addr_t;

    // Base opcodes, only those the decoder looks at
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, OP2
    } fun_t;

    typedef enum logic [2:0] {
        NONE, JUMP, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } br_t;

    typedef enum logic {RS1, PC} op1_t;
    typedef enum logic {RS2, IMM} op2_t;

    // Operand source, youngest producer wins
    typedef enum logic [1:0] {REG, EXE, WB} rs_t;

    typedef struct packed {
        logic [6:0] funct7;
        addr_t      rs2;
        addr_t      rs1;
        logic [2:0] funct3;
        addr_t      rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        addr_t       rs1;
        logic [2:0]  funct3;
        addr_t       rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        addr_t      rs2;
        addr_t      rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        addr_t      rs2;
        addr_t      rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        addr_t       rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        addr_t      rd;
        opcode_t    opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_t;

    typedef struct packed {
        logic valid;
        fun_t fun;
        br_t  br;
        logic writes;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        inst_t ir;
    } id_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t op1;
        word_t op2;
        word_t rs1;
        word_t rs2;
        addr_t rd;
    } ex_t;

    typedef struct packed {
        addr_t rd;
        word_t data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== src/decode.sv ====
// Instruction decode stage
// Control decoder, immediate generation, operand forwarding
// and the decode to execute pipeline register
`timescale 1ns/100ps
`default_nettype none

module decode (
    input  logic            sink,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  core_pkg::id_t   in_data,
    output core_pkg::addr_t rs1_addr,
    output core_pkg::addr_t rs2_addr,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    input  core_pkg::rs_t   rs1_sel,
    input  core_pkg::rs_t   rs2_sel,
    input  core_pkg::word_t alu_data,
    input  core_pkg::word_t wb_value,
    output logic            invalid,
    output logic            ex_valid,
    input  logic            ex_ready,
    output core_pkg::ex_t   ex_data
);

    localparam core_pkg::ctrl_t BUBBLE = '{
        valid:  1'b0,
        fun:    core_pkg::ADD,
        br:     core_pkg::NONE,
        writes: 1'b0
    };

    // alt is instruction bit 30 where it selects SUB or SRA
    function automatic core_pkg::fun_t alu_fun(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  alu_fun = alt ? core_pkg::SUB : core_pkg::ADD;
            3'b001:  alu_fun = core_pkg::SLL;
            3'b010:  alu_fun = core_pkg::SLT;
            3'b011:  alu_fun = core_pkg::SLTU;
            3'b100:  alu_fun = core_pkg::XOR;
            3'b101:  alu_fun = alt ? core_pkg::SRA : core_pkg::SRL;
            3'b110:  alu_fun = core_pkg::OR;
            default: alu_fun = core_pkg::AND;
        endcase
    endfunction

    function automatic core_pkg::word_t forward(
        input core_pkg::rs_t   sel,
        input core_pkg::word_t reg_value,
        input core_pkg::word_t exe_value,
        input core_pkg::word_t wb_val
    );
        case (sel)
            core_pkg::EXE: forward = exe_value;
            core_pkg::WB:  forward = wb_val;
            default:       forward = reg_value;
        endcase
    endfunction

    core_pkg::word_t pc;
    core_pkg::inst_t ir;
    core_pkg::ctrl_t ctrl;
    core_pkg::op1_t  op1_sel;
    core_pkg::op2_t  op2_sel;
    core_pkg::word_t i_imm;
    core_pkg::word_t u_imm;
    core_pkg::word_t b_imm;
    core_pkg::word_t j_imm;
    core_pkg::word_t imm;
    core_pkg::word_t rs1;
    core_pkg::word_t rs2;
    core_pkg::word_t op1;
    core_pkg::word_t op2;
    core_pkg::addr_t rd;
    logic            imm_ok;
    logic            reg_ok;

    assign pc = in_data.pc;
    assign ir = in_data.ir;

    assign rs1_addr = ir.r.rs1;
    assign rs2_addr = ir.r.rs2;

    assign i_imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
    assign u_imm = {ir.u.imm_31_12, 12'b0};
    assign b_imm = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                    ir.b.imm_4_1, 1'b0};
    assign j_imm = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                    ir.j.imm_10_1, 1'b0};

    // Shift immediates reserve funct7 apart from the SRAI bit
    assign imm_ok = (ir.r.funct3 != 3'b001 && ir.r.funct3 != 3'b101)
                  || ir.r.funct7 == 7'h00
                  || (ir.r.funct3 == 3'b101 && ir.r.funct7 == 7'h20);
    assign reg_ok = ir.r.funct7 == 7'h00
                  || (ir.r.funct7 == 7'h20 && (ir.r.funct3 == 3'b000 || ir.r.funct3 == 3'b101));

    always_comb begin
        ctrl    = BUBBLE;
        op1_sel = core_pkg::RS1;
        op2_sel = core_pkg::IMM;
        imm     = i_imm;
        case (ir.r.opcode)
            core_pkg::OP_IMM: begin
                ctrl.valid  = imm_ok;
                ctrl.writes = imm_ok;
                ctrl.fun    = alu_fun(ir.r.funct3, ir.r.funct3 == 3'b101 && ir.r.funct7[5]);
            end
            core_pkg::OP: begin
                ctrl.valid  = reg_ok;
                ctrl.writes = reg_ok;
                ctrl.fun    = alu_fun(ir.r.funct3, ir.r.funct7[5]);
                op2_sel     = core_pkg::RS2;
            end
            core_pkg::LUI: begin
                ctrl = '{valid: 1'b1, fun: core_pkg::OP2, br: core_pkg::NONE, writes: 1'b1};
                imm  = u_imm;
            end
            core_pkg::AUIPC: begin
                ctrl    = '{valid: 1'b1, fun: core_pkg::ADD, br: core_pkg::NONE, writes: 1'b1};
                op1_sel = core_pkg::PC;
                imm     = u_imm;
            end
            core_pkg::JAL: begin
                ctrl    = '{valid: 1'b1, fun: core_pkg::ADD, br: core_pkg::JUMP, writes: 1'b1};
                op1_sel = core_pkg::PC;
                imm     = j_imm;
            end
            core_pkg::JALR: begin
                if (ir.r.funct3 == 3'b000) begin
                    ctrl = '{valid: 1'b1, fun: core_pkg::ADD, br: core_pkg::JUMP, writes: 1'b1};
                end
            end
            core_pkg::BRANCH: begin
                op1_sel = core_pkg::PC;
                imm     = b_imm;
                case (ir.r.funct3)
                    3'b000:  ctrl.br = core_pkg::BEQ;
                    3'b001:  ctrl.br = core_pkg::BNE;
                    3'b100:  ctrl.br = core_pkg::BLT;
                    3'b101:  ctrl.br = core_pkg::BGE;
                    3'b110:  ctrl.br = core_pkg::BLTU;
                    3'b111:  ctrl.br = core_pkg::BGEU;
                    default: ctrl.br = core_pkg::NONE;
                endcase
                ctrl.valid = ctrl.br != core_pkg::NONE;
            end
            // Loads, stores and unknown encodings go down as bubbles
            default: ctrl = BUBBLE;
        endcase
    end

    assign rs1 = forward(rs1_sel, rs1_data, alu_data, wb_value);
    assign rs2 = forward(rs2_sel, rs2_data, alu_data, wb_value);

    assign op1 = (op1_sel == core_pkg::PC) ? pc : rs1;
    assign op2 = (op2_sel == core_pkg::RS2) ? rs2 : imm;

    // Branches and bubbles leave with rd zero
    assign rd = ctrl.writes ? ir.r.rd : '0;

    assign in_ready = !ex_valid || ex_ready;
    assign invalid  = in_valid && in_ready && !ctrl.valid;

    always_ff @(posedge sink) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (in_ready) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge sink) begin
        if (in_valid && in_ready) begin
            ex_data <= '{ctrl: ctrl, pc: pc, op1: op1, op2: op2, rs1: rs1, rs2: rs2, rd: rd};
        end
    end

endmodule

`default_nettype wire

// ==== src/decode_core.sv ====
// Pipeline top level
// Decode and execute stages, forwarding unit and register file
`timescale 1ns/100ps
`default_nettype none

module decode_core (
    input  logic                sink,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_ready,
    input  core_pkg::id_t       in_data,
    output logic                wb_valid,
    input  logic                wb_ready,
    output core_pkg::wb_t       wb_data,
    output core_pkg::redirect_t redirect,
    output logic                invalid
);

    core_pkg::addr_t rs1_addr;
    core_pkg::addr_t rs2_addr;
    core_pkg::word_t rs1_data;
    core_pkg::word_t rs2_data;
    core_pkg::rs_t   rs1_sel;
    core_pkg::rs_t   rs2_sel;
    core_pkg::word_t alu_data;
    logic            ex_valid;
    logic            ex_ready;
    core_pkg::ex_t   ex_data;

    regfile i_regfile (
        .sink     (sink),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid && wb_ready),
        .wr       (wb_data)
    );

    forward_unit i_forward_unit (
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_data.rd),
        .ex_writes (ex_data.ctrl.writes),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_data.rd),
        .rs1_sel   (rs1_sel),
        .rs2_sel   (rs2_sel)
    );

    decode i_decode (
        .sink     (sink),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .alu_data (alu_data),
        .wb_value (wb_data.data),
        .invalid  (invalid),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex_data  (ex_data)
    );

    execute i_execute (
        .sink     (sink),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_ready (ex_ready),
        .ex_data  (ex_data),
        .alu_data (alu_data),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

// ==== src/execute.sv ====
// Execute stage
// ALU, branch comparator, link value, branch target
// and the execute to write-back register
`timescale 1ns/100ps
`default_nettype none

module execute (
    input  logic                sink,
    input  logic                reset,
    input  logic                ex_valid,
    output logic                ex_ready,
    input  core_pkg::ex_t       ex_data,
    output core_pkg::word_t     alu_data,
    output logic                wb_valid,
    input  logic                wb_ready,
    output core_pkg::wb_t       wb_data,
    output core_pkg::redirect_t redirect
);

    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t alu_result;
    core_pkg::word_t sum;
    core_pkg::word_t target;
    core_pkg::word_t target_q;
    logic            is_jump;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;
    logic            taken_q;

    assign a       = ex_data.op1;
    assign b       = ex_data.op2;
    assign is_jump = ex_data.ctrl.br == core_pkg::JUMP;

    always_comb begin
        case (ex_data.ctrl.fun)
            core_pkg::SUB:  alu_result = a - b;
            core_pkg::SLL:  alu_result = a << b[4:0];
            core_pkg::SLT:  alu_result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::SLTU: alu_result = {31'b0, a < b};
            core_pkg::XOR:  alu_result = a ^ b;
            core_pkg::SRL:  alu_result = a >> b[4:0];
            core_pkg::SRA:  alu_result = $signed(a) >>> b[4:0];
            core_pkg::OR:   alu_result = a | b;
            core_pkg::AND:  alu_result = a & b;
            core_pkg::OP2:  alu_result = b;
            default:        alu_result = a + b;
        endcase
    end

    // Compare on register values, op1 may hold the pc
    assign eq  = ex_data.rs1 == ex_data.rs2;
    assign lt  = $signed(ex_data.rs1) < $signed(ex_data.rs2);
    assign ltu = ex_data.rs1 < ex_data.rs2;

    always_comb begin
        case (ex_data.ctrl.br)
            core_pkg::JUMP: taken = 1'b1;
            core_pkg::BEQ:  taken = eq;
            core_pkg::BNE:  taken = !eq;
            core_pkg::BLT:  taken = lt;
            core_pkg::BGE:  taken = !lt;
            core_pkg::BLTU: taken = ltu;
            core_pkg::BGEU: taken = !ltu;
            default:        taken = 1'b0;
        endcase
    end

    // Bit 0 clear matters for JALR only, JAL targets are even
    assign sum    = a + b;
    assign target = {sum[31:1], sum[0] && !is_jump};

    assign alu_data = is_jump ? ex_data.pc + 32'd4 : alu_result;
    assign ex_ready = !wb_valid || wb_ready;

    always_ff @(posedge sink) begin
        if (reset) begin
            wb_valid <= 1'b0;
            taken_q  <= 1'b0;
        end else if (ex_ready) begin
            wb_valid <= ex_valid && ex_data.ctrl.valid;
            taken_q  <= ex_valid && ex_data.ctrl.valid && taken;
        end
    end

    always_ff @(posedge sink) begin
        if (ex_valid && ex_ready) begin
            wb_data  <= '{rd: ex_data.rd, data: alu_data};
            target_q <= target;
        end
    end

    assign redirect = '{taken: taken_q, target: target_q};

endmodule

`default_nettype wire

// ==== src/forward_unit.sv ====
// Operand forwarding select
// Matches source registers against the execute and write-back items
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
    input  core_pkg::addr_t rs1_addr,
    input  core_pkg::addr_t rs2_addr,
    input  logic            ex_valid,
    input  core_pkg::addr_t ex_rd,
    input  logic            ex_writes,
    input  logic            wb_valid,
    input  core_pkg::addr_t wb_rd,
    output core_pkg::rs_t   rs1_sel,
    output core_pkg::rs_t   rs2_sel
);

    function automatic core_pkg::rs_t pick(
        input core_pkg::addr_t addr,
        input logic            ex_live,
        input core_pkg::addr_t ex_dst,
        input logic            wb_live,
        input core_pkg::addr_t wb_dst
    );
        if (addr == '0) begin
            pick = core_pkg::REG;
        end else if (ex_live && ex_dst == addr) begin
            pick = core_pkg::EXE;
        end else if (wb_live && wb_dst == addr) begin
            pick = core_pkg::WB;
        end else begin
            pick = core_pkg::REG;
        end
    endfunction

    logic ex_live;

    // Non-writers in write-back already carry rd zero
    assign ex_live = ex_valid && ex_writes;

    assign rs1_sel = pick(rs1_addr, ex_live, ex_rd, wb_valid, wb_rd);
    assign rs2_sel = pick(rs2_addr, ex_live, ex_rd, wb_valid, wb_rd);

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
// Integer register file
// Registers x1 to x31, two combinational read ports, one write port
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic            sink,
    input  logic            reset,
    input  core_pkg::addr_t rs1_addr,
    input  core_pkg::addr_t rs2_addr,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data,
    input  logic            wr_en,
    input  core_pkg::wb_t   wr
);

    // x0 has no storage
    core_pkg::word_t regs [1:31];

    always_ff @(posedge sink) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Same-cycle write is not visible here, forwarding covers it
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire
